/* Makefile */
TOOL  = verilator
FLAGS = --binary -j 0
TOP   = tb_ctl_spi
FLIST = sim.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

/* design/ctl_reg_file.sv */
// Control register file of the board.
// Decodes each finished 16-bit frame and applies set/clear/toggle to one register.
// The soft reset address and rst_n both load the defaults.

`timescale 1ns/1ns

module ctl_reg_file (
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_regs_pkg::frame_u   frame,
  input  spi_regs_pkg::cnt_t     bits,
  input  logic                   frame_done,
  output spi_regs_pkg::ctl_nib_t reg_led,
  output spi_regs_pkg::ctl_nib_t reg_mux,
  output spi_regs_pkg::ctl_nib_t reg_dac,
  output spi_regs_pkg::ctl_nib_t reg_rails,
  output spi_regs_pkg::ctl_nib_t reg_clamp1,
  output spi_regs_pkg::ctl_nib_t reg_rails_oe
);

  import spi_regs_pkg::*;

  // frame is complete and exactly one word long
  logic wr_ok;
  logic soft_rst;
  cmd_t cmd;

  assign cmd      = frame.cmd;
  assign wr_ok    = frame_done && (bits == cnt_t'(frame_w));
  assign soft_rst = wr_ok && (cmd.addr == addr_soft_rst);

  ////////////////////////////////////////////////////
  // register storage

  always_ff @(posedge clk)
  begin
    if (!rst_n || soft_rst)
    begin
      reg_led      <= dflt_led;
      reg_mux      <= dflt_mux;
      reg_dac      <= dflt_dac;
      reg_rails    <= dflt_rails;
      reg_clamp1   <= dflt_clamp1;
      reg_rails_oe <= dflt_rails_oe;
    end
    else if (wr_ok)
    begin
      // unlisted addresses fall through untouched
      case (cmd.addr)
        addr_led:
        begin
          reg_led <= nib_update(reg_led, cmd);
        end
        addr_mux:
        begin
          // peripheral select mask for the router
          reg_mux <= nib_update(reg_mux, cmd);
        end
        addr_dac:
        begin
          reg_dac <= nib_update(reg_dac, cmd);
        end
        addr_rails:
        begin
          reg_rails <= nib_update(reg_rails, cmd);
        end
        addr_clamp1:
        begin
          reg_clamp1 <= nib_update(reg_clamp1, cmd);
        end
        addr_rails_oe:
        begin
          reg_rails_oe <= nib_update(reg_rails_oe, cmd);
        end
        default:
        begin
        end
      endcase
    end
  end

endmodule

/* design/ctl_spi_top.sv */
// Top level of the SPI control register bank.
// Pins in, six 4-bit control registers and routed peripheral cs/miso out.
// n_periph sets how many peripherals share the SPI bus.

`timescale 1ns/1ns

module ctl_spi_top #(
  parameter int n_periph = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sclk,
  input  logic                   cs,
  input  logic                   mosi,
  input  logic                   special,
  input  logic [n_periph-1:0]    periph_miso,
  output logic                   miso,
  output logic [n_periph-1:0]    periph_cs,
  output spi_regs_pkg::ctl_nib_t reg_led,
  output spi_regs_pkg::ctl_nib_t reg_mux,
  output spi_regs_pkg::ctl_nib_t reg_dac,
  output spi_regs_pkg::ctl_nib_t reg_rails,
  output spi_regs_pkg::ctl_nib_t reg_clamp1,
  output spi_regs_pkg::ctl_nib_t reg_rails_oe
);

  import spi_regs_pkg::*;

  frame_u frame;
  cnt_t   bits;
  logic   frame_done;
  // bank miso before the router
  logic   dout;

  spi_evt_if evt ();

  ////////////////////////////////////////////////////
  // pins into clk domain

  spi_sync u_sync (
    .clk   (clk),
    .rst_n (rst_n),
    .sclk  (sclk),
    .cs    (cs),
    .mosi  (mosi),
    .evt   (evt.src)
  );

  spi_frame_rx u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .evt        (evt.dst),
    .frame      (frame),
    .bits       (bits),
    .frame_done (frame_done),
    .dout       (dout)
  );

  ////////////////////////////////////////////////////
  // registers and routing

  ctl_reg_file u_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .frame        (frame),
    .bits         (bits),
    .frame_done   (frame_done),
    .reg_led      (reg_led),
    .reg_mux      (reg_mux),
    .reg_dac      (reg_dac),
    .reg_rails    (reg_rails),
    .reg_clamp1   (reg_clamp1),
    .reg_rails_oe (reg_rails_oe)
  );

  periph_route #(
    .n_periph (n_periph)
  ) u_route (
    .special     (special),
    .cs          (cs),
    .dout        (dout),
    .reg_mux     (reg_mux),
    .periph_miso (periph_miso),
    .periph_cs   (periph_cs),
    .miso        (miso)
  );

endmodule

/* design/periph_route.sv */
// Chip-select fan-out and miso select for the routed SPI peripherals.
// special low talks to the bank, special high routes cs to the reg_mux selection.
// Purely combinational, follows the pins directly.

`timescale 1ns/1ns

module periph_route #(
  parameter int n_periph = 4
) (
  input  logic                   special,
  input  logic                   cs,
  input  logic                   dout,
  input  spi_regs_pkg::ctl_nib_t reg_mux,
  input  logic [n_periph-1:0]    periph_miso,
  output logic [n_periph-1:0]    periph_cs,
  output logic                   miso
);

  // one reg_mux bit per peripheral, upper bits unused when n_periph is small
  logic [n_periph-1:0] sel;

  assign sel = reg_mux[n_periph-1:0];

  always_comb
  begin
    if (!special)
    begin
      // bank traffic, keep every peripheral deselected
      periph_cs = '1;
      miso      = dout;
    end
    else
    begin
      // active low, only selected lines follow cs
      periph_cs = ~(sel & {n_periph{~cs}});
      // unselected peripherals masked off the shared line
      miso      = |(periph_miso & sel);
    end
  end

endmodule

/* design/spi_evt_if.sv */
// Synchronized SPI events, from the pin synchronizer to the frame receiver.
// Strobes are single clk cycles, no handshake or stall.

`timescale 1ns/1ns

interface spi_evt_if;

  // one cycle after each synchronized sclk falling edge
  logic sclk_fall;
  // one cycle as cs returns high, ends a frame
  logic cs_rise;
  // high while cs is low, aligned with the strobes
  logic cs_act;
  // mosi after the synchronizer
  logic mosi_s;

  modport src (
    output sclk_fall,
    output cs_rise,
    output cs_act,
    output mosi_s
  );

  modport dst (
    input sclk_fall,
    input cs_rise,
    input cs_act,
    input mosi_s
  );

endinterface

/* design/spi_frame_rx.sv */
// SPI frame receiver in the clk domain.
// Shifts mosi into the frame, counts bits and shifts the id word out on dout.
// frame, bits and frame_done go to the register file.

`timescale 1ns/1ns

module spi_frame_rx (
  input  logic                 clk,
  input  logic                 rst_n,
  spi_evt_if.dst               evt,
  output spi_regs_pkg::frame_u frame,
  output spi_regs_pkg::cnt_t   bits,
  output logic                 frame_done,
  output logic                 dout
);

  import spi_regs_pkg::*;

  // outgoing id word, msb drives dout
  logic [frame_w-1:0] id_sr;

  ////////////////////////////////////////////////////
  // incoming data

  // payload only, the bit count says whether it is whole
  always_ff @(posedge clk)
  begin
    if (evt.cs_act && evt.sclk_fall)
    begin
      // enters at the lsb end, first bit ends up in the address msb
      frame.raw <= {frame.raw[frame_w-2:0], evt.mosi_s};
    end
  end

  ////////////////////////////////////////////////////
  // bit count and id shifter

  always_ff @(posedge clk)
  begin
    if (!rst_n || !evt.cs_act)
    begin
      // idle between frames, ready for the next one
      bits  <= '0;
      id_sr <= id_word;
    end
    else if (evt.sclk_fall)
    begin
      // saturate, an overlong frame must not alias to 16
      if (bits != '1)
      begin
        bits <= bits + cnt_t'(1);
      end
      // zero fill once the word is gone
      id_sr <= {id_sr[frame_w-2:0], 1'b0};
    end
  end

  assign dout = id_sr[frame_w-1];

  // same cycle as cs_rise, bits still holds the count
  assign frame_done = evt.cs_rise;

endmodule

/* design/spi_regs_pkg.sv */
// Shared definitions for the SPI control register bank.
// Frame layout, register addresses, reset defaults and the nibble update rule.
// Imported by the receiver, the register file and the top level.

package spi_regs_pkg;

  ////////////////////////////////////////////////////
  // widths and types

  localparam int nib_w   = 4;
  localparam int frame_w = 16;
  // two spare bits so overlong frames never wrap back to 16
  localparam int cnt_w   = $clog2(frame_w) + 2;

  typedef logic [nib_w-1:0] ctl_nib_t;
  typedef logic [cnt_w-1:0] cnt_t;
  typedef logic [7:0]       addr_t;

  // high byte address, then clear nibble above set nibble
  typedef struct packed {
    addr_t    addr;
    ctl_nib_t clr_nib;
    ctl_nib_t set_nib;
  } cmd_t;

  // receiver fills raw, register file reads cmd
  typedef union packed {
    logic [frame_w-1:0] raw;
    cmd_t               cmd;
  } frame_u;

  ////////////////////////////////////////////////////
  // register map

  localparam addr_t addr_led      = 8'd7;
  localparam addr_t addr_mux      = 8'd8;
  localparam addr_t addr_dac      = 8'd9;
  localparam addr_t addr_rails    = 8'd10;
  localparam addr_t addr_soft_rst = 8'd11;
  localparam addr_t addr_clamp1   = 8'd15;
  localparam addr_t addr_rails_oe = 8'd24;

  // defaults, also loaded by the soft reset address
  localparam ctl_nib_t dflt_led      = 4'b0000;
  localparam ctl_nib_t dflt_mux      = 4'b0000;
  localparam ctl_nib_t dflt_dac      = 4'b0000;
  localparam ctl_nib_t dflt_rails    = 4'b0000;
  // clamp lines are active low, so all off
  localparam ctl_nib_t dflt_clamp1   = 4'b1111;
  // bit 0 is the active low rail enable, keep rails off
  localparam ctl_nib_t dflt_rails_oe = 4'b0001;

  // identification word shifted out on miso
  localparam logic [frame_w-1:0] id_word = 16'hFF00;

  ////////////////////////////////////////////////////
  // set/clear/toggle rule

  function automatic ctl_nib_t nib_update(input ctl_nib_t old, input cmd_t cmd);
    ctl_nib_t both;
    both = cmd.set_nib & cmd.clr_nib;
    // bits named in both nibbles flip, the rest hold
    if (both != '0)
      return old ^ both;
    // set first, clear wins after
    return (old | cmd.set_nib) & ~cmd.clr_nib;
  endfunction

endpackage

/* design/spi_sync.sv */
// Brings the asynchronous SPI pins into the clk domain.
// Two flops per pin, a third on sclk and cs for registered edge strobes.

`timescale 1ns/1ns

module spi_sync (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   sclk,
  input  logic   cs,
  input  logic   mosi,
  spi_evt_if.src evt
);

  // [0] first stage, [1] second stage
  logic [1:0] sclk_sync;
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;

  // delayed copies for edge detect
  logic sclk_d;
  logic cs_d;

  logic sclk_fall_q;
  logic cs_rise_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sclk_sync   <= 2'b00;
      // cs idles high, not selected
      cs_sync     <= 2'b11;
      mosi_sync   <= 2'b00;
      sclk_d      <= 1'b0;
      cs_d        <= 1'b1;
      sclk_fall_q <= 1'b0;
      cs_rise_q   <= 1'b0;
    end
    else
    begin
      sclk_sync   <= {sclk_sync[0], sclk};
      cs_sync     <= {cs_sync[0], cs};
      mosi_sync   <= {mosi_sync[0], mosi};
      sclk_d      <= sclk_sync[1];
      cs_d        <= cs_sync[1];
      // strobes land 3 cycles after the pin edge
      sclk_fall_q <= sclk_d & ~sclk_sync[1];
      cs_rise_q   <= cs_sync[1] & ~cs_d;
    end
  end

  assign evt.sclk_fall = sclk_fall_q;
  assign evt.cs_rise   = cs_rise_q;
  // taken from the third flop so it drops in the cs_rise cycle
  assign evt.cs_act    = ~cs_d;
  assign evt.mosi_s    = mosi_sync[1];

endmodule

/* sim.f */
design/spi_regs_pkg.sv
design/spi_evt_if.sv
design/spi_sync.sv
design/spi_frame_rx.sv
design/ctl_reg_file.sv
design/periph_route.sv
design/ctl_spi_top.sv
tests/tb_clkgen.sv
tests/tb_ctl_spi.sv

/* tests/tb_clkgen.sv */
// Clock and reset source for the register bank testbench.
// 4 ns clk, rst_n held low for the first 16 rising edges.

`timescale 1ns/1ns

module tb_clkgen #(
  parameter int half_ns    = 2,
  parameter int rst_cycles = 16
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #half_ns clk = ~clk;
  end

  // released on a rising edge, like the rest of the stimulus
  initial
  begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* tests/tb_ctl_spi.sv */
// Testbench for the SPI control register bank.
// Random frames from a fixed seed against a register model, id word readback
// on miso and peripheral routing checks, one summary line at the end.

`timescale 1ns/1ns

module tb_ctl_spi;

  import spi_regs_pkg::*;

  localparam int n_periph = 4;
  // sclk half period in clk cycles
  localparam int half_per = 8;

  logic                clk;
  logic                rst_n;
  logic                sclk = 1'b0;
  logic                cs = 1'b1;
  logic                mosi = 1'b0;
  logic                special = 1'b0;
  logic [n_periph-1:0] periph_miso = '0;
  logic                miso;
  logic [n_periph-1:0] periph_cs;
  ctl_nib_t            reg_led;
  ctl_nib_t            reg_mux;
  ctl_nib_t            reg_dac;
  ctl_nib_t            reg_rails;
  ctl_nib_t            reg_clamp1;
  ctl_nib_t            reg_rails_oe;

  int seed = 27;
  int mismatches = 0;
  int timeouts = 0;

  // model state, index order matches data_addrs
  addr_t    data_addrs [6] = '{addr_led, addr_mux, addr_dac, addr_rails, addr_clamp1,
                               addr_rails_oe};
  ctl_nib_t dflts [6] = '{dflt_led, dflt_mux, dflt_dac, dflt_rails, dflt_clamp1, dflt_rails_oe};
  ctl_nib_t m_reg [6];

  tb_clkgen u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  ctl_spi_top #(
    .n_periph (n_periph)
  ) u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .sclk         (sclk),
    .cs           (cs),
    .mosi         (mosi),
    .special      (special),
    .periph_miso  (periph_miso),
    .miso         (miso),
    .periph_cs    (periph_cs),
    .reg_led      (reg_led),
    .reg_mux      (reg_mux),
    .reg_dac      (reg_dac),
    .reg_rails    (reg_rails),
    .reg_clamp1   (reg_clamp1),
    .reg_rails_oe (reg_rails_oe)
  );

  //////////////////////////////////////////////////
  // reference model

  // overlap flips those bits, otherwise set then clear
  function automatic ctl_nib_t model_rule(input ctl_nib_t old, input ctl_nib_t s,
                                          input ctl_nib_t c);
    ctl_nib_t r;
    logic     ovl;
    int       b;
    r   = old;
    ovl = |(s & c);
    for (b = 0; b < nib_w; b++)
    begin
      if (ovl)
        r[b] = old[b] ^ (s[b] & c[b]);
      else if (c[b])
        r[b] = 1'b0;
      else if (s[b])
        r[b] = 1'b1;
    end
    return r;
  endfunction

  task automatic load_defaults();
    int k;
    for (k = 0; k < 6; k++)
      m_reg[k] = dflts[k];
  endtask

  // only called for whole 16-bit frames
  task automatic model_write(input logic [15:0] w);
    int k;
    if (w[15:8] == addr_soft_rst)
      load_defaults();
    for (k = 0; k < 6; k++)
    begin
      if (w[15:8] == data_addrs[k])
        m_reg[k] = model_rule(m_reg[k], w[3:0], w[7:4]);
    end
  endtask

  function automatic logic listed(input addr_t a);
    int k;
    listed = (a == addr_soft_rst);
    for (k = 0; k < 6; k++)
      listed = listed | (a == data_addrs[k]);
  endfunction

  //////////////////////////////////////////////////
  // compare tasks

  task automatic check_nib(input string name, input ctl_nib_t got, input ctl_nib_t exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_regs();
    check_nib("reg_led", reg_led, m_reg[0]);
    check_nib("reg_mux", reg_mux, m_reg[1]);
    check_nib("reg_dac", reg_dac, m_reg[2]);
    check_nib("reg_rails", reg_rails, m_reg[3]);
    check_nib("reg_clamp1", reg_clamp1, m_reg[4]);
    check_nib("reg_rails_oe", reg_rails_oe, m_reg[5]);
  endtask

  // periph_cs always, shared miso only while routed
  task automatic check_route();
    int   b;
    logic exp_cs;
    for (b = 0; b < n_periph; b++)
    begin
      exp_cs = special ? ~(m_reg[1][b] & ~cs) : 1'b1;
      check_bit($sformatf("periph_cs[%0d]", b), periph_cs[b], exp_cs);
    end
    if (special)
      check_bit("miso", miso, |(periph_miso & m_reg[1][n_periph-1:0]));
  endtask

  //////////////////////////////////////////////////
  // pin stimulus

  task automatic wait_cycles(input int n);
    int i;
    for (i = 0; i < n; i++)
      @(posedge clk);
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (!rst_n && n < 100)
    begin
      @(posedge clk);
      n++;
    end
    if (!rst_n)
    begin
      $display("timeout: rst_n was never released");
      timeouts++;
    end
  endtask

  // msb first, miso checked just before each sclk fall
  task automatic send_frame(input logic [31:0] word, input int nbits);
    int i;
    @(posedge clk);
    cs <= 1'b0;
    wait_cycles(half_per);
    for (i = 0; i < nbits; i++)
    begin
      @(posedge clk);
      mosi <= word[nbits-1-i];
      sclk <= 1'b1;
      wait_cycles(half_per - 1);
      @(negedge clk);
      // id word first, zero fill after
      check_bit("miso", miso, (i < frame_w) ? id_word[frame_w-1-i] : 1'b0);
      @(posedge clk);
      sclk <= 1'b0;
      wait_cycles(half_per - 1);
    end
    wait_cycles(half_per);
    @(posedge clk);
    cs <= 1'b1;
    // 4 cycles to the register write, one spare
    wait_cycles(5);
    @(negedge clk);
  endtask

  task automatic write_random();
    logic [31:0] rnd;
    logic [15:0] w;
    rnd = $random(seed);
    w   = {data_addrs[int'(rnd[23:16]) % 6], rnd[7:0]};
    send_frame({16'h0000, w}, 16);
    model_write(w);
    check_regs();
  endtask

  // last 16 bits shifted in form a listed write, only the bit count is wrong
  task automatic send_bad_length();
    logic [31:0] rnd;
    logic [15:0] t;
    ctl_nib_t    m;
    int          nb;
    rnd = $random(seed);
    nb  = 1 + int'(rnd[7:0]) % 19;
    if (nb >= frame_w)
      nb++;
    // toggle pattern, an accepted frame would always change the register
    m   = rnd[11:8] | 4'b0001;
    t   = {data_addrs[int'(rnd[23:16]) % 6], m, m};
    if (nb < frame_w)
    begin
      // unlisted lead frame, the short tail then completes t in the shifter
      send_frame({16'h0000, 16'h8000 | (t >> nb)}, 16);
      check_regs();
    end
    send_frame({rnd[31:16], t}, nb);
    check_regs();
  endtask

  //////////////////////////////////////////////////
  // test sequence

  initial
  begin
    int          i;
    logic [31:0] rnd;
    addr_t       a;
    load_defaults();
    wait_reset();
    wait_cycles(2);
    @(negedge clk);
    // defaults and idle chip selects
    check_regs();
    check_route();

    for (i = 0; i < 200; i++)
      write_random();

    // soft reset after random traffic
    send_frame({16'h0000, addr_soft_rst, 8'h00}, 16);
    model_write({addr_soft_rst, 8'h00});
    check_regs();

    // bad lengths and unlisted addresses change nothing
    for (i = 0; i < 20; i++)
    begin
      write_random();
      send_bad_length();
      rnd = $random(seed);
      a   = rnd[15:8];
      if (listed(a))
        a = a ^ 8'h80;
      send_frame({16'h0000, a, rnd[7:0]}, 16);
      check_regs();
    end

    // routed mode, mux written through the bank first
    for (i = 0; i < 20; i++)
    begin
      rnd = $random(seed);
      send_frame({16'h0000, addr_mux, rnd[7:0]}, 16);
      model_write({addr_mux, rnd[7:0]});
      check_regs();
      @(posedge clk);
      special     <= 1'b1;
      periph_miso <= rnd[19:16];
      @(negedge clk);
      check_route();
      @(posedge clk);
      cs <= 1'b0;
      @(negedge clk);
      check_route();
      @(posedge clk);
      periph_miso <= rnd[23:20];
      @(negedge clk);
      check_route();
      @(posedge clk);
      cs <= 1'b1;
      @(negedge clk);
      check_route();
      @(posedge clk);
      special <= 1'b0;
      // let the empty cs pulse drain through the synchronizer
      wait_cycles(6);
    end

    $display("summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule
